//--- list.f
+incdir+.
vx_mem_pkg.sv
vx_req_queue.sv
vx_local_mem.sv
vx_io_timer.sv
vx_io_apb_master.sv
vx_mem_port.sv
vx_mem_port_properties.sv
tb_vx_mem_port.sv

//--- Bender.yml
package:
  name: vx_mem_port

sources:
  - include_dirs:
      - .
    files:
      - vx_mem_pkg.sv
      - vx_req_queue.sv
      - vx_local_mem.sv
      - vx_io_timer.sv
      - vx_io_apb_master.sv
      - vx_mem_port.sv
  - target: test
    include_dirs:
      - .
    files:
      - vx_mem_port_properties.sv
      - tb_vx_mem_port.sv

//--- tb_vx_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "vx_mem_config.svh"

module tb_vx_mem_port
    import vx_mem_pkg::*;
();

    localparam int          NUM_REQS       = 300;
    localparam int          CYCLES_PER_REQ = 40;
    localparam int          CLK_PERIOD     = 100;
    localparam int          TIMEOUT_CYCLES = NUM_REQS * CYCLES_PER_REQ;
    localparam int unsigned SEED           = 99695;

    logic      clk;
    logic      arst_n;
    logic      req_valid;
    core_req_t req;
    logic      req_ready;
    logic      rsp_valid;
    core_rsp_t rsp;
    logic      rsp_ready;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    logic      busy;

    int unsigned               req_seed;
    int unsigned               rsp_seed;
    int unsigned               apb_seed;
    logic [`VX_DATA_WIDTH-1:0] lmem_ref   [`VX_LMEM_WORDS];
    logic [`VX_DATA_WIDTH-1:0] regs_ref   [16];
    logic [`VX_DATA_WIDTH-1:0] slave_regs [16];
    core_rsp_t                 exp_q [$];
    core_req_t                 io_q [$];
    int                        rsp_count;
    logic                      in_access;
    int unsigned               wait_left;
    int                        access_cycles;

    vx_mem_port vx_mem_port_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .busy      (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned next_random(inout int unsigned state);
        state = state * 32'd1103515245 + 32'd12345;
        return state >> 8;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic core_req_t random_request(inout int unsigned state,
                                                 input logic [3:0]  tag);
        core_req_t   r;
        int unsigned hi;
        int unsigned sel;
        r.rw     = 1'(next_random(state) % 2);
        r.byteen = 4'(next_random(state) % 16);
        hi       = next_random(state);
        r.data   = (hi << 16) ^ next_random(state);
        r.tag    = tag;
        if (next_random(state) % 3 != 0) begin
            // Small window so local words get rewritten and read back
            r.addr = 16'h0040 + 16'(next_random(state) % 8);
        end else begin
            r.addr = `VX_IO_BASE_ADDR + 16'(next_random(state) % 4);
            sel    = next_random(state) % 16;
            if (sel == 0) begin
                r.addr[8] = 1'b1;
            end else if (sel < 3) begin
                r.addr[9] = 1'b1;
            end
        end
        return r;
    endfunction

    // Reference model, updated in request order
    function automatic core_rsp_t predict_rsp(input core_req_t r);
        core_rsp_t e;
        e.data = '0;
        e.tag  = r.tag;
        e.err  = 1'b0;
        if (r.addr < `VX_IO_BASE_ADDR) begin
            if (r.rw) begin
                lmem_ref[r.addr[7:0]] = merge_bytes(lmem_ref[r.addr[7:0]], r.data, r.byteen);
            end else begin
                e.data = lmem_ref[r.addr[7:0]];
            end
        end else if (r.addr[8] || r.addr[9]) begin
            e.err = 1'b1;
        end else if (r.rw) begin
            regs_ref[r.addr[3:0]] = merge_bytes(regs_ref[r.addr[3:0]], r.data, r.byteen);
        end else begin
            e.data = regs_ref[r.addr[3:0]];
        end
        return e;
    endfunction

    function automatic apb_req_t apb_from_req(input core_req_t r);
        apb_req_t a;
        a.paddr   = r.addr;
        a.psel    = 1'b1;
        a.penable = 1'b1;
        a.pwrite  = r.rw;
        a.pwdata  = r.data;
        a.pstrb   = r.byteen;
        return a;
    endfunction

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_rsp(input core_rsp_t got, input core_rsp_t exp);
        if (got !== exp) begin
            $display("FAILED %0t rsp got data=%h tag=%h err=%b expected data=%h tag=%h err=%b",
                     $time, got.data, got.tag, got.err, exp.data, exp.tag, exp.err);
            stop_with_failure();
        end
    endtask

    task automatic compare_apb(input apb_req_t got, input apb_req_t exp);
        if (got !== exp) begin
            $display("FAILED %0t apb_req got addr=%h wr=%b wdata=%h strb=%h",
                     $time, got.paddr, got.pwrite, got.pwdata, got.pstrb);
            $display("FAILED %0t apb_req expected addr=%h wr=%b wdata=%h strb=%h",
                     $time, exp.paddr, exp.pwrite, exp.pwdata, exp.pstrb);
            stop_with_failure();
        end
    endtask

    // APB slave with random wait states
    always @(negedge clk) begin
        if (!arst_n || !apb_req.psel) begin
            // Bit 8 slots never answer, so only the timer ends the access
            if (in_access && apb_req.paddr[8] && access_cycles != `VX_IO_TIMEOUT) begin
                $display("FAILED %0t penable cycles got %0d expected %0d",
                         $time, access_cycles, `VX_IO_TIMEOUT);
                stop_with_failure();
            end else begin
                in_access = 1'b0;
                apb_rsp   = '0;
            end
        end else if (apb_req.penable) begin
            if (!in_access) begin
                in_access     = 1'b1;
                access_cycles = 0;
                wait_left     = next_random(apb_seed) % 4;
                if (io_q.size() == 0) begin
                    $display("ERROR: APB transfer started with no I/O request outstanding");
                    stop_with_failure();
                end else begin
                    compare_apb(apb_req, apb_from_req(io_q.pop_front()));
                end
            end
            access_cycles++;
            if (wait_left == 0 && !apb_req.paddr[8]) begin
                apb_rsp.pready = 1'b1;
                if (apb_req.paddr[9]) begin
                    apb_rsp.pslverr = 1'b1;
                    apb_rsp.prdata  = '0;
                end else begin
                    apb_rsp.pslverr = 1'b0;
                    apb_rsp.prdata  = slave_regs[apb_req.paddr[3:0]];
                    if (apb_req.pwrite) begin
                        slave_regs[apb_req.paddr[3:0]] = merge_bytes(
                            slave_regs[apb_req.paddr[3:0]], apb_req.pwdata, apb_req.pstrb);
                    end
                end
            end else begin
                apb_rsp = '0;
                if (wait_left > 0) begin
                    wait_left--;
                end
            end
        end
    end

    // Response side, checked at the falling edge before the transfer edge
    always @(negedge clk) begin
        if (arst_n) begin
            rsp_ready = 1'(next_random(rsp_seed) % 2);
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: response delivered with no request outstanding");
                    stop_with_failure();
                end else begin
                    compare_rsp(rsp, exp_q.pop_front());
                    rsp_count++;
                end
            end
        end
    end

    initial begin
        core_req_t r;
        clk           = 1'b0;
        arst_n        = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        rsp_ready     = 1'b0;
        apb_rsp       = '0;
        req_seed      = SEED;
        rsp_seed      = SEED ^ 32'h5a5a5a5a;
        apb_seed      = SEED ^ 32'h3c3c3c3c;
        rsp_count     = 0;
        in_access     = 1'b0;
        wait_left     = 0;
        access_cycles = 0;
        for (int i = 0; i < `VX_LMEM_WORDS; i++) begin
            lmem_ref[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            regs_ref[i]   = '0;
            slave_regs[i] = '0;
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < NUM_REQS; i++) begin
            r = random_request(req_seed, 4'(i));
            exp_q.push_back(predict_rsp(r));
            if (r.addr >= `VX_IO_BASE_ADDR) begin
                io_q.push_back(r);
            end
            req_valid = 1'b1;
            req       = r;
            while (!req_ready) @(negedge clk);
            @(negedge clk);
        end
        req_valid = 1'b0;
        req       = '0;
        while (rsp_count < NUM_REQS) @(negedge clk);
        // Last response has left the queue by the next falling edge
        @(negedge clk);
        if (busy || rsp_valid || io_q.size() != 0) begin
            $display("ERROR: DUT still busy or requests left unanswered at end of run");
            stop_with_failure();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, DUT stopped responding",
                 TIMEOUT_CYCLES);
        stop_with_failure();
    end

endmodule

`default_nettype wire

//--- vx_mem_port_properties.sv
`timescale 1ns/1ps
`default_nettype none

module vx_mem_port_properties
    import vx_mem_pkg::*;
(
    input wire            clk,
    input wire            arst_n,
    input wire            rsp_valid,
    input wire            rsp_ready,
    input wire core_rsp_t rsp,
    input wire apb_req_t  apb_req,
    input wire            busy
);

    penable_needs_psel: assert property (
        @(posedge clk) disable iff (!arst_n)
        apb_req.penable |-> apb_req.psel
    ) else $error("penable high without psel");

    // Stalled response stays put
    rsp_held_when_stalled: assert property (
        @(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    ) else $error("rsp changed or dropped while stalled");

    idle_after_reset: assert property (
        @(posedge clk)
        $rose(arst_n) |-> !busy && !rsp_valid && !apb_req.psel
    ) else $error("port not idle when reset released");

endmodule

bind vx_mem_port vx_mem_port_properties vx_mem_port_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .apb_req   (apb_req),
    .busy      (busy)
);

`default_nettype wire

//--- vx_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "vx_mem_config.svh"

module vx_mem_port
    import vx_mem_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            req_valid,
    input  wire core_req_t req,
    output logic           req_ready,
    output logic           rsp_valid,
    output core_rsp_t      rsp,
    input  wire            rsp_ready,
    output apb_req_t       apb_req,
    input  wire apb_rsp_t  apb_rsp,
    output logic           busy
);

    logic      init_done;
    logic      req_full;
    logic      req_empty;
    logic      req_pop;
    core_req_t req_head;
    logic      rsp_full;
    logic      rsp_empty;
    logic      rsp_push;
    core_rsp_t rsp_push_data;
    logic      io_select;
    logic      issue_ok;
    logic      local_issue;
    logic      io_start;
    logic      lmem_rsp_valid;
    core_rsp_t lmem_rsp;
    logic      io_done;
    logic      io_idle;
    core_rsp_t io_rsp;

    // Port opens one cycle after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
        end
    end

    assign req_ready = init_done && !req_full;

    vx_req_queue #(
        .payload_t (core_req_t),
        .DEPTH     (`VX_QUEUE_DEPTH)
    ) req_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (req_valid && req_ready),
        .push_data (req),
        .full      (req_full),
        .pop       (req_pop),
        .pop_data  (req_head),
        .empty     (req_empty)
    );

    assign io_select = (req_head.addr >= `VX_IO_BASE_ADDR);

    // A local response in flight may take the last free slot
    assign issue_ok    = !req_empty && !rsp_full && !lmem_rsp_valid;
    assign local_issue = issue_ok && !io_select;
    assign io_start    = issue_ok && io_select && io_idle;
    assign req_pop     = local_issue || io_done;

    vx_local_mem local_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .en        (local_issue),
        .req       (req_head),
        .rsp_valid (lmem_rsp_valid),
        .rsp       (lmem_rsp)
    );

    vx_io_apb_master io_master (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (io_start),
        .req     (req_head),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .done    (io_done),
        .rsp     (io_rsp),
        .idle    (io_idle)
    );

    // Never both valid in one cycle
    assign rsp_push      = lmem_rsp_valid || io_done;
    assign rsp_push_data = io_done ? io_rsp : lmem_rsp;

    vx_req_queue #(
        .payload_t (core_rsp_t),
        .DEPTH     (`VX_QUEUE_DEPTH)
    ) rsp_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (rsp_push),
        .push_data (rsp_push_data),
        .full      (rsp_full),
        .pop       (rsp_ready),
        .pop_data  (rsp),
        .empty     (rsp_empty)
    );

    assign rsp_valid = !rsp_empty;
    assign busy      = !req_empty || !rsp_empty || !io_idle || lmem_rsp_valid;

endmodule

`default_nettype wire

//--- vx_io_apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module vx_io_apb_master
    import vx_mem_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            start,
    input  wire core_req_t req,
    output apb_req_t       apb_req,
    input  wire apb_rsp_t  apb_rsp,
    output logic           done,
    output core_rsp_t      rsp,
    output logic           idle
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        DONE
    } state_e;

    state_e    state;
    state_e    next_state;
    core_req_t req_q;
    logic      timer_start;
    logic      timer_stop;
    logic      expired;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (start) next_state = SETUP;
            SETUP:   next_state = ACCESS;
            ACCESS:  if (apb_rsp.pready || expired) next_state = DONE;
            DONE:    next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Timer covers the access phase only
    assign timer_start = (state == SETUP);
    assign timer_stop  = (state == ACCESS) && apb_rsp.pready;

    vx_io_timer io_timer (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (timer_start),
        .stop    (timer_stop),
        .expired (expired)
    );

    // Request held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            req_q <= req;
        end
        if (state == ACCESS) begin
            if (apb_rsp.pready) begin
                rsp.data <= req_q.rw ? '0 : apb_rsp.prdata;
                rsp.tag  <= req_q.tag;
                rsp.err  <= apb_rsp.pslverr;
            end else if (expired) begin
                rsp.data <= '0;
                rsp.tag  <= req_q.tag;
                rsp.err  <= 1'b1;
            end
        end
    end

    assign apb_req.paddr   = req_q.addr;
    assign apb_req.psel    = (state == SETUP) || (state == ACCESS);
    assign apb_req.penable = (state == ACCESS);
    assign apb_req.pwrite  = req_q.rw;
    assign apb_req.pwdata  = req_q.data;
    assign apb_req.pstrb   = req_q.byteen;

    assign done = (state == DONE);
    assign idle = (state == IDLE);

endmodule

`default_nettype wire

//--- vx_io_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vx_mem_config.svh"

module vx_io_timer (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  start,
    input  wire  stop,
    output logic expired
);

    localparam int CNT_W = $clog2(`VX_IO_TIMEOUT + 1);

    logic [CNT_W-1:0] count;
    logic             running;

    // High in the last allowed cycle only, running drops with it
    assign expired = running && (count == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count   <= '0;
            running <= 1'b0;
        end else if (stop) begin
            running <= 1'b0;
        end else if (start) begin
            count   <= CNT_W'(`VX_IO_TIMEOUT - 1);
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- vx_local_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "vx_mem_config.svh"

module vx_local_mem
    import vx_mem_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            en,
    input  wire core_req_t req,
    output logic           rsp_valid,
    output core_rsp_t      rsp
);

    localparam int IDX_W = $clog2(`VX_LMEM_WORDS);

    logic [`VX_DATA_WIDTH-1:0] words [`VX_LMEM_WORDS];
    logic [IDX_W-1:0]          idx;

    assign idx = req.addr[IDX_W-1:0];

    // Byte-enable merge on stores
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `VX_LMEM_WORDS; i++) begin
                words[i] <= '0;
            end
        end else if (en && req.rw) begin
            for (int b = 0; b < `VX_BYTEEN_WIDTH; b++) begin
                if (req.byteen[b]) begin
                    words[idx][b*8 +: 8] <= req.data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= en;
        end
    end

    // Loads see all earlier stores, stores answer with zero
    always_ff @(posedge clk) begin
        if (en) begin
            rsp.data <= req.rw ? '0 : words[idx];
            rsp.tag  <= req.tag;
            rsp.err  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- vx_req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module vx_req_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire           clk,
    input  wire           arst_n,
    input  wire           push,
    input  wire payload_t push_data,
    output logic          full,
    input  wire           pop,
    output payload_t      pop_data,
    output logic          empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;

    // Head is visible without a pop
    assign pop_data = slots[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

//--- vx_mem_pkg.sv
`default_nettype none

`include "vx_mem_config.svh"

package vx_mem_pkg;

    // Core load or store, rw set for a store
    typedef struct packed {
        logic                        rw;
        logic [`VX_BYTEEN_WIDTH-1:0] byteen;
        logic [`VX_ADDR_WIDTH-1:0]   addr;
        logic [`VX_DATA_WIDTH-1:0]   data;
        logic [`VX_TAG_WIDTH-1:0]    tag;
    } core_req_t;

    typedef struct packed {
        logic [`VX_DATA_WIDTH-1:0]   data;
        logic [`VX_TAG_WIDTH-1:0]    tag;
        logic                        err;
    } core_rsp_t;

    // APB master outputs
    typedef struct packed {
        logic [`VX_ADDR_WIDTH-1:0]   paddr;
        logic                        psel;
        logic                        penable;
        logic                        pwrite;
        logic [`VX_DATA_WIDTH-1:0]   pwdata;
        logic [`VX_BYTEEN_WIDTH-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic [`VX_DATA_WIDTH-1:0]   prdata;
        logic                        pready;
        logic                        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- vx_mem_config.svh
`ifndef VX_MEM_CONFIG_SVH
`define VX_MEM_CONFIG_SVH

// Core request word address and data
`define VX_ADDR_WIDTH   16
`define VX_DATA_WIDTH   32
`define VX_TAG_WIDTH    4
`define VX_BYTEEN_WIDTH 4

// Word addresses from here upward go to the I/O bus
`define VX_IO_BASE_ADDR 16'hC000

// Local data memory depth in words
`define VX_LMEM_WORDS   256

// Request and response queue depth
`define VX_QUEUE_DEPTH  4

// Cycles allowed in the APB access phase
`define VX_IO_TIMEOUT   16

`endif
